/* hdl/edge_buffer_bank.sv */
`timescale 1ns/1ps
`include "gnn_defines.svh"

module edge_buffer_bank
    import gnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  pe2bank_t   pe_pkt,
    output bank2rs_t   rs_pkt,
    input  logic       rs_credit,
    output bank2sram_t outbuff_pkt,
    input  logic       sram_grant,
    output logic       bank_busy
);

    localparam int PAIRS = `FV_NUM / 2;
    localparam int PW    = $clog2(PAIRS);
    localparam int CW    = $clog2(`RS_DEPTH + 1);

    bank_state_e state;

    logic [PAIRS-1:0][1:0][`FV_WIDTH-1:0] buffer;
    logic [PW-1:0]             pair;        // Current element pair
    logic [PW-1:0]             last_pair;   // Stream length minus one
    logic [`NODE_ID_WIDTH-1:0] cur_nodeid;
    logic                      acc_open;    // Buffer holds a partial sum
    logic                      flag_done;
    logic                      flag_wb;
    logic [CW-1:0]             credit;
    logic                      beat_in;
    logic                      send;

    assign beat_in = pe_pkt.valid && (state == STREAM_IN || (state == IDLE && pe_pkt.sos));
    assign send    = (state == OUT_RS) && (credit != '0);

    assign bank_busy = !(state == IDLE || state == STREAM_IN) || (pe_pkt.valid && pe_pkt.eos);

    always_comb begin
        outbuff_pkt        = '0;
        outbuff_pkt.nodeid = cur_nodeid;
        outbuff_pkt.fv     = buffer[pair];
        outbuff_pkt.req    = (state == OUT_FV_WAIT);
        if (state == OUT_FV) begin
            outbuff_pkt.valid = 1'b1;
            outbuff_pkt.sos   = (pair == '0);
            outbuff_pkt.eos   = (pair == last_pair);
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= IDLE;
            buffer     <= '0;
            pair       <= '0;
            last_pair  <= '0;
            cur_nodeid <= '0;
            acc_open   <= 1'b0;
            flag_done  <= 1'b0;
            flag_wb    <= 1'b0;
            credit     <= CW'(`RS_DEPTH);
            rs_pkt     <= '0;
        end else begin
            credit       <= credit + CW'(rs_credit) - CW'(send);
            rs_pkt.valid <= 1'b0;

            case (state)
                IDLE, STREAM_IN: begin
                    if (beat_in) begin
                        buffer[pair][0] <= buffer[pair][0] + pe_pkt.fv[0];    // Wraps mod 2^FV_WIDTH
                        buffer[pair][1] <= buffer[pair][1] + pe_pkt.fv[1];
                        if (pe_pkt.sos && !acc_open) begin
                            cur_nodeid <= pe_pkt.nodeid;
                            acc_open   <= 1'b1;
                        end
                        if (pe_pkt.eos) begin
                            last_pair <= pair;
                            flag_done <= pe_pkt.done_aggr;
                            flag_wb   <= pe_pkt.wb_en;
                            pair      <= '0;
                            state     <= COMPLETE;
                        end else begin
                            pair  <= pair + 1'b1;
                            state <= STREAM_IN;
                        end
                    end
                end
                COMPLETE: begin
                    if (flag_done) begin
                        state <= OUT_RS;
                    end else if (flag_wb) begin
                        state <= OUT_FV_WAIT;
                    end else begin
                        state <= IDLE;    // Keep the partial sum for the next edge
                    end
                end
                OUT_RS: begin
                    if (send) begin
                        rs_pkt <= '{valid:  1'b1,
                                    sos:    (pair == '0),
                                    eos:    (pair == last_pair),
                                    nodeid: cur_nodeid,
                                    fv:     buffer[pair]};
                        pair <= pair + 1'b1;
                        if (pair == last_pair) begin
                            state    <= IDLE;
                            buffer   <= '0;
                            pair     <= '0;
                            acc_open <= 1'b0;
                        end
                    end
                end
                OUT_FV_WAIT: begin
                    if (sram_grant) begin
                        state <= OUT_FV;
                    end
                end
                OUT_FV: begin
                    pair <= pair + 1'b1;    // Writer never stalls
                    if (pair == last_pair) begin
                        state    <= IDLE;
                        buffer   <= '0;
                        pair     <= '0;
                        acc_open <= 1'b0;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Queue returns at most one credit per beat it was sent
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!reset)
        credit <= CW'(`RS_DEPTH)
    );

    // Outside must see bank_busy low the cycle before a new stream enters
    a_sos_not_busy: assert property (
        @(posedge clk) disable iff (!reset)
        pe_pkt.valid && pe_pkt.sos |-> !$past(bank_busy)
    );

endmodule

/* hdl/edge_pe.sv */
`timescale 1ns/1ps

module edge_pe
    import gnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  edge_beat_t edge_in,
    output pe2bank_t   pe_pkt
);

    logic in_stream;    // Between a sos beat and its eos beat

    always_ff @(posedge clk) begin
        if (!reset) begin
            pe_pkt.valid <= 1'b0;
            pe_pkt.sos   <= 1'b0;
            pe_pkt.eos   <= 1'b0;
        end else begin
            pe_pkt.valid <= edge_in.valid;
            pe_pkt.sos   <= edge_in.valid && edge_in.sos;
            pe_pkt.eos   <= edge_in.valid && edge_in.eos;
            if (edge_in.valid) begin
                pe_pkt.nodeid    <= edge_in.nodeid;
                pe_pkt.done_aggr <= edge_in.done_aggr;
                pe_pkt.wb_en     <= edge_in.wb_en;
                for (int i = 0; i < 2; i++) begin
                    pe_pkt.fv[i] <= edge_in.fv[i] * edge_in.weight;    // Truncated product
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            in_stream <= 1'b0;
        end else if (edge_in.valid) begin
            in_stream <= !edge_in.eos;
        end
    end

    // A new stream only opens after the previous one has closed
    a_sos_after_eos: assert property (
        @(posedge clk) disable iff (!reset)
        edge_in.valid && edge_in.sos |-> !in_stream
    );

endmodule

/* hdl/gnn_aggr_top.sv */
`timescale 1ns/1ps
`include "gnn_defines.svh"

module gnn_aggr_top
    import gnn_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  edge_beat_t                edge_in,
    output logic                      bank_busy,
    output bank2rs_t                  rs_out,
    input  logic                      rs_ready,
    input  logic                      sram_rd_en,
    input  logic [`NODE_ID_WIDTH-1:0] sram_rd_addr,
    output sram_rd_t                  sram_rd_data
);

    pe2bank_t   pe_pkt;
    bank2rs_t   rs_pkt;
    bank2sram_t outbuff_pkt;
    logic       rs_credit;
    logic       sram_grant;

    edge_pe u_pe (
        .clk     (clk),
        .reset   (reset),
        .edge_in (edge_in),
        .pe_pkt  (pe_pkt)
    );

    edge_buffer_bank u_bank (
        .clk         (clk),
        .reset       (reset),
        .pe_pkt      (pe_pkt),
        .rs_pkt      (rs_pkt),
        .rs_credit   (rs_credit),
        .outbuff_pkt (outbuff_pkt),
        .sram_grant  (sram_grant),
        .bank_busy   (bank_busy)
    );

    output_sram_writer u_writer (
        .clk          (clk),
        .reset        (reset),
        .outbuff_pkt  (outbuff_pkt),
        .sram_grant   (sram_grant),
        .sram_rd_en   (sram_rd_en),
        .sram_rd_addr (sram_rd_addr),
        .sram_rd_data (sram_rd_data)
    );

    rs_queue u_rsq (
        .clk       (clk),
        .reset     (reset),
        .rs_pkt    (rs_pkt),
        .rs_credit (rs_credit),
        .rs_out    (rs_out),
        .rs_ready  (rs_ready)
    );

endmodule

/* hdl/gnn_defines.svh */
`ifndef GNN_DEFINES_SVH
`define GNN_DEFINES_SVH

// Feature vector shape
`define FV_NUM 8
`define FV_WIDTH 16

// Node addressing
`define NODE_ID_WIDTH 4

// Reservation station queue depth and initial credit
`define RS_DEPTH 4

// One output SRAM row per node id
`define SRAM_NODES 16

`endif

/* hdl/gnn_pkg.sv */
`include "gnn_defines.svh"

package gnn_pkg;

    typedef struct packed {
        logic                          valid;
        logic                          sos;
        logic                          eos;
        logic [`NODE_ID_WIDTH-1:0]     nodeid;
        logic [`FV_WIDTH-1:0]          weight;
        logic [1:0][`FV_WIDTH-1:0]     fv;
        logic                          done_aggr;
        logic                          wb_en;
    } edge_beat_t;

    typedef struct packed {
        logic                          valid;
        logic                          sos;
        logic                          eos;
        logic [`NODE_ID_WIDTH-1:0]     nodeid;
        logic [1:0][`FV_WIDTH-1:0]     fv;    // Already weighted
        logic                          done_aggr;
        logic                          wb_en;
    } pe2bank_t;

    typedef struct packed {
        logic                          valid;
        logic                          sos;
        logic                          eos;
        logic [`NODE_ID_WIDTH-1:0]     nodeid;
        logic [1:0][`FV_WIDTH-1:0]     fv;
    } bank2rs_t;

    typedef struct packed {
        logic                          req;
        logic                          valid;
        logic                          sos;
        logic                          eos;
        logic [`NODE_ID_WIDTH-1:0]     nodeid;
        logic [1:0][`FV_WIDTH-1:0]     fv;
    } bank2sram_t;

    typedef struct packed {
        logic [`FV_NUM-1:0][`FV_WIDTH-1:0] fv;   // One whole node row
    } sram_rd_t;

    typedef enum logic [2:0] {
        IDLE,
        STREAM_IN,
        COMPLETE,
        OUT_RS,
        OUT_FV_WAIT,
        OUT_FV
    } bank_state_e;

endpackage

/* hdl/output_sram_writer.sv */
`timescale 1ns/1ps
`include "gnn_defines.svh"

module output_sram_writer
    import gnn_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  bank2sram_t                outbuff_pkt,
    output logic                      sram_grant,
    input  logic                      sram_rd_en,
    input  logic [`NODE_ID_WIDTH-1:0] sram_rd_addr,
    output sram_rd_t                  sram_rd_data
);

    localparam int PW = $clog2(`FV_NUM / 2);

    sram_rd_t      mem [`SRAM_NODES];
    logic          busy;    // Receiving a granted vector
    logic [PW-1:0] pair;

    always_ff @(posedge clk) begin
        if (!reset) begin
            busy       <= 1'b0;
            sram_grant <= 1'b0;
            pair       <= '0;
        end else begin
            sram_grant <= 1'b0;
            if (!busy && outbuff_pkt.req) begin
                sram_grant <= 1'b1;    // Single cycle grant
                busy       <= 1'b1;
            end
            if (busy && outbuff_pkt.valid) begin
                pair <= pair + 1'b1;
                if (outbuff_pkt.eos) begin
                    busy <= 1'b0;
                    pair <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int n = 0; n < `SRAM_NODES; n++) begin
                mem[n] <= '0;
            end
        end else if (busy && outbuff_pkt.valid) begin
            mem[outbuff_pkt.nodeid].fv[{pair, 1'b0}] <= outbuff_pkt.fv[0];
            mem[outbuff_pkt.nodeid].fv[{pair, 1'b1}] <= outbuff_pkt.fv[1];
        end
    end

    always_ff @(posedge clk) begin
        if (sram_rd_en) begin
            sram_rd_data <= mem[sram_rd_addr];
        end
    end

    // Bank starts a writeback only on the cycle after a grant
    a_beat_after_grant: assert property (
        @(posedge clk) disable iff (!reset)
        outbuff_pkt.valid && outbuff_pkt.sos |-> $past(sram_grant)
    );

endmodule

/* hdl/rs_queue.sv */
`timescale 1ns/1ps
`include "gnn_defines.svh"

module rs_queue
    import gnn_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  bank2rs_t rs_pkt,
    output logic     rs_credit,
    output bank2rs_t rs_out,
    input  logic     rs_ready
);

    localparam int AW = $clog2(`RS_DEPTH);
    localparam int CW = $clog2(`RS_DEPTH + 1);

    bank2rs_t      mem [`RS_DEPTH];
    logic [AW-1:0] head;
    logic [AW-1:0] tail;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign push      = rs_pkt.valid;
    assign pop       = rs_out.valid && rs_ready;
    assign rs_credit = pop;    // One credit back per dequeued beat

    always_comb begin
        rs_out       = mem[head];
        rs_out.valid = (count != '0);
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            count <= count + CW'(push) - CW'(pop);
            if (push) begin
                tail <= (tail == AW'(`RS_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == AW'(`RS_DEPTH - 1)) ? '0 : head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= rs_pkt;
        end
    end

    // A push into a full queue means the bank overspent its credit
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!reset)
        push |-> count < CW'(`RS_DEPTH)
    );

endmodule

/* project.f */
+incdir+hdl
hdl/gnn_pkg.sv
hdl/edge_pe.sv
hdl/edge_buffer_bank.sv
hdl/output_sram_writer.sv
hdl/rs_queue.sv
hdl/gnn_aggr_top.sv
test/tb_gnn_aggr.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_gnn_aggr -o sim_gnn \
    && ./obj_dir/sim_gnn | tee /dev/stderr | grep -qx "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* test/tb_gnn_aggr.sv */
`timescale 1ns/1ps
`include "gnn_defines.svh"

module tb_gnn_aggr
    import gnn_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int PAIRS       = `FV_NUM / 2;
    localparam int MAX_STREAMS = 29;    // Upper bound of streams sent by the sequence below

    logic                      clk = 1'b0;
    logic                      reset;
    edge_beat_t                edge_in;
    logic                      bank_busy;
    bank2rs_t                  rs_out;
    logic                      rs_ready = 1'b0;
    logic                      sram_rd_en;
    logic [`NODE_ID_WIDTH-1:0] sram_rd_addr;
    sram_rd_t                  sram_rd_data;

    logic [1:0][`FV_WIDTH-1:0] exp_sum [`SRAM_NODES][PAIRS];    // Running weighted sum per node
    sram_rd_t                  exp_row [`SRAM_NODES];
    bank2rs_t                  exp_q [$];
    logic [31:0]               rng = 32'h1f26;
    logic [31:0]               rdy_rng = 32'h1f26;
    bit                        started = 1'b0;
    bit                        hold_ready = 1'b0;
    int                        n_checks = 0;
    int                        value_errors = 0;
    int                        proto_errors = 0;

    gnn_aggr_top u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input string name, input logic [63:0] want, input logic [63:0] got);
        n_checks++;
        assert (got == want) else begin
            value_errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, want, got);
        end
    endtask

    // Random 16-bit operands make most products and many sums overflow
    task automatic send_stream(input int node, input int len, input bit done, input bit wb);
        logic [`FV_WIDTH-1:0]      w;
        logic [1:0][`FV_WIDTH-1:0] f;
        logic [31:0]               prod;
        while (bank_busy) @(negedge clk);
        rng = xorshift32(rng);
        w = rng[15:0];
        for (int k = 0; k < len; k++) begin
            if (k > 0) @(negedge clk);
            rng = xorshift32(rng);
            f = rng;
            edge_in = '{valid: 1'b1, sos: (k == 0), eos: (k == len - 1),
                        nodeid: node[`NODE_ID_WIDTH-1:0], weight: w, fv: f,
                        done_aggr: done, wb_en: wb};
            for (int e = 0; e < 2; e++) begin
                prod = f[e] * w;    // Low half of the full product
                exp_sum[node][k][e] = exp_sum[node][k][e] + prod[`FV_WIDTH-1:0];
            end
            started = 1'b1;
        end
        @(negedge clk);
        edge_in = '0;
        for (int k = 0; k < len; k++) begin
            if (done) begin
                exp_q.push_back('{valid: 1'b1, sos: (k == 0), eos: (k == len - 1),
                                  nodeid: node[`NODE_ID_WIDTH-1:0], fv: exp_sum[node][k]});
            end else if (wb) begin
                exp_row[node].fv[2*k]   = exp_sum[node][k][0];
                exp_row[node].fv[2*k+1] = exp_sum[node][k][1];
            end
            if (done || wb) exp_sum[node][k] = '0;
        end
    endtask

    task automatic wait_idle();
        int waited = 0;
        while (bank_busy && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        if (bank_busy) begin
            proto_errors++;
            $display("Bank still busy after 400 cycles at %0t", $time);
        end
    endtask

    task automatic drain_rs();
        int waited = 0;
        while (exp_q.size() != 0 && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            proto_errors++;
            $display("%0d expected rs_out beats never arrived by %0t", exp_q.size(), $time);
        end
    endtask

    task automatic read_row(input int node);
        sram_rd_en   = 1'b1;
        sram_rd_addr = node[`NODE_ID_WIDTH-1:0];
        @(negedge clk);
        sram_rd_en = 1'b0;
        for (int i = 0; i < `FV_NUM; i++) begin
            compare($sformatf("sram_rd_data.fv[%0d]", i), exp_row[node].fv[i], sram_rd_data.fv[i]);
        end
    endtask

    task automatic set_hold(input bit v);
        @(posedge clk);
        hold_ready = v;
        @(negedge clk);
    endtask

    // Issue stage model that checks every dequeued beat in order
    always @(negedge clk) begin
        bank2rs_t want;
        rdy_rng = xorshift32(rdy_rng);
        rs_ready = !hold_ready && (rdy_rng[1:0] != 2'b00);
        if (rs_out.valid && rs_ready) begin
            if (exp_q.size() == 0) begin
                proto_errors++;
                $display("rs_out delivered a beat at %0t while none was expected", $time);
            end else begin
                want = exp_q.pop_front();
                compare("rs_out.sos", want.sos, rs_out.sos);
                compare("rs_out.eos", want.eos, rs_out.eos);
                compare("rs_out.nodeid", want.nodeid, rs_out.nodeid);
                compare("rs_out.fv", want.fv, rs_out.fv);
            end
        end
    end

    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (!reset)
        !started |-> !rs_out.valid && !bank_busy
    ) else begin
        proto_errors++;
        $display("rs_out.valid or bank_busy high before the first stream at %0t", $time);
    end

    a_stall_holds: assert property (
        @(posedge clk) disable iff (!reset)
        rs_out.valid && !rs_ready |=> rs_out.valid && $stable(rs_out.fv)
    ) else begin
        proto_errors++;
        $display("rs_out head beat changed or vanished while stalled at %0t", $time);
    end

    initial begin
        #(CLK_PERIOD * (200 * MAX_STREAMS + 1000));
        $display("Watchdog expired before the test sequence finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int len;
        int n_str;
        bit wb;
        foreach (exp_sum[n, k]) exp_sum[n][k] = '0;
        foreach (exp_row[n]) exp_row[n] = '0;
        reset        = 1'b0;
        edge_in      = '0;
        sram_rd_en   = 1'b0;
        sram_rd_addr = '0;
        repeat (2) @(negedge clk);
        reset = 1'b1;
        repeat (4) @(negedge clk);
        compare("rs_out.valid", 0, rs_out.valid);
        compare("bank_busy", 0, bank_busy);

        // Three edges into node 1 with the last one sent to the reservation station
        send_stream(1, 2, 0, 0);
        send_stream(1, 2, 0, 0);
        send_stream(1, 2, 1, 0);
        drain_rs();

        // Partial sum of node 5 written back and then a fresh sum for it
        send_stream(5, 3, 0, 0);
        send_stream(5, 3, 0, 1);
        wait_idle();
        read_row(5);
        send_stream(5, 3, 0, 0);
        send_stream(5, 3, 1, 0);
        drain_rs();

        // Node 3 fills the stalled queue and node 4 waits for credit
        set_hold(1'b1);
        send_stream(3, 4, 0, 0);
        send_stream(3, 4, 1, 0);
        send_stream(4, 4, 0, 0);
        send_stream(4, 4, 1, 0);
        repeat (20) @(negedge clk);
        compare("bank_busy", 1, bank_busy);
        compare("rs_out.valid", 1, rs_out.valid);
        compare("rs_out.sos", 1, rs_out.sos);
        compare("rs_out.fv", exp_q[0].fv, rs_out.fv);
        set_hold(1'b0);
        drain_rs();

        for (int n = 8; n < 14; n++) begin
            rng   = xorshift32(rng);
            len   = 1 + rng[1:0];
            n_str = 1 + rng[3:2] % 3;
            wb    = rng[4];
            for (int s = 1; s < n_str; s++) send_stream(n, len, 0, 0);
            send_stream(n, len, !wb, wb);
            wait_idle();
            if (wb) read_row(n);
        end
        drain_rs();
        wait_idle();
        compare("pending rs_out beats", 0, exp_q.size());

        $display("checks: %0d, value errors: %0d, protocol errors: %0d",
                 n_checks, value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
